// ==== common/qctl_defines.svh ====
// global widths and counts of the pulse generator, included by the packages, RTL and testbench.
`ifndef QCTL_DEFINES_SVH
`define QCTL_DEFINES_SVH

// time counter and trigger time width.
`define QCTL_TIME_W 24

// envelope address width, 256 entries per element.
`define QCTL_ENV_AW 8

// width of one I or Q sample component.
`define QCTL_SAMP_W 16

// number of waveform elements.
`define QCTL_NELEM 4

// width of one host command word.
`define QCTL_CMD_W 64

`endif

// ==== common/qctl_cmd_pkg.sv ====
// command-side types (time, envelope address, channel, command words), imported by the RTL.
`default_nettype none

`include "qctl_defines.svh"

package qctl_cmd_pkg;

	typedef logic [`QCTL_TIME_W-1:0] time_t;
	typedef logic [`QCTL_ENV_AW-1:0] env_addr_t;
	typedef logic [$clog2(`QCTL_NELEM)-1:0] chan_t;

	// unused top bits of the command word.
	localparam int unsigned CMD_RSVD_W = `QCTL_CMD_W - $bits(chan_t) - `QCTL_TIME_W
		- 2 * `QCTL_ENV_AW - `QCTL_SAMP_W;

	// host command, chan in the msbs.
	typedef struct packed {
		chan_t                   chan;
		time_t                   trigt;     // fire when tcnt equals this.
		env_addr_t               envstart;
		env_addr_t               envlength; // samples minus one.
		logic [`QCTL_SAMP_W-1:0] amp;       // q1.15 bits, read as amp_t.
		logic [CMD_RSVD_W-1:0]   rsvd;
	} wave_cmd_t;

	// per-pulse setup handed to an element with its start strobe.
	typedef struct packed {
		env_addr_t               envstart;
		env_addr_t               envlength;
		logic [`QCTL_SAMP_W-1:0] amp;
	} elem_start_t;

endpackage

`default_nettype wire

// ==== common/qctl_wave_pkg.sv ====
// sample-side types (amplitude, I/Q samples, envelope writes), imported by the RTL.
`default_nettype none

`include "qctl_defines.svh"

package qctl_wave_pkg;

	import qctl_cmd_pkg::chan_t;
	import qctl_cmd_pkg::env_addr_t;

	typedef logic signed [`QCTL_SAMP_W-1:0] amp_t;  // q1.15.
	typedef logic signed [`QCTL_SAMP_W-1:0] samp_t;

	typedef struct packed {
		samp_t i;
		samp_t q;
	} iq_t;

	// one envelope ram write, routed by chan.
	typedef struct packed {
		chan_t     chan;
		env_addr_t addr;
		iq_t       data;
	} env_wr_t;

endpackage

`default_nettype wire

// ==== element/env_ram.sv ====
// envelope memory of one element, host write port and sequencer read port with one cycle latency.
`timescale 1ns/1ps
`default_nettype none

`include "qctl_defines.svh"

module env_ram
	import qctl_cmd_pkg::*, qctl_wave_pkg::*;
(
	input  wire logic      elem,
	input  wire logic      we,
	input  wire env_addr_t waddr,
	input  wire iq_t       wdata,
	input  wire env_addr_t raddr,
	output iq_t            rdata
);

	localparam int unsigned DEPTH = 1 << `QCTL_ENV_AW;

	iq_t mem [DEPTH];

	always_ff @(posedge elem) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
		rdata <= mem[raddr]; // registered read.
	end

endmodule

`default_nettype wire

// ==== element/elem_seq.sv ====
// one waveform element: envelope address walk, amplitude scaling and output valid.
`timescale 1ns/1ps
`default_nettype none

`include "qctl_defines.svh"

module elem_seq
	import qctl_cmd_pkg::*, qctl_wave_pkg::*;
(
	input  wire logic        elem,
	input  wire logic        rst,
	input  wire logic        start,
	input  wire elem_start_t cfg,
	input  wire logic        env_wr_en,
	input  wire env_wr_t     env_wr,
	output logic             valid,
	output iq_t              iq
);

	typedef enum logic {
		IDLE,
		RUN
	} seq_state_t;

	seq_state_t state;
	env_addr_t  addr;
	env_addr_t  end_addr;
	amp_t       amp_a;   // amplitude of the address stage.
	amp_t       amp_d;   // amplitude of the data stage.
	logic       valid_d;
	iq_t        env_q;
	logic signed [2*`QCTL_SAMP_W-1:0] prod_i;
	logic signed [2*`QCTL_SAMP_W-1:0] prod_q;

	env_ram ram0 (
		.elem  (elem),
		.we    (env_wr_en),
		.waddr (env_wr.addr),
		.wdata (env_wr.data),
		.raddr (addr),
		.rdata (env_q)
	);

	// a start while running restarts the walk.
	always_ff @(posedge elem) begin
		if (rst) begin
			state <= IDLE;
		end else if (start) begin
			state <= RUN;
		end else if ((state == RUN) && (addr == end_addr)) begin
			state <= IDLE;
		end
	end

	always_ff @(posedge elem) begin
		if (start) begin
			addr <= cfg.envstart;
			end_addr <= cfg.envstart + cfg.envlength; // wraps within the ram.
			amp_a <= amp_t'(cfg.amp);
		end else if (state == RUN) begin
			addr <= addr + 1'b1;
		end
	end

	// ram data stage.
	always_ff @(posedge elem) begin
		if (rst) begin
			valid_d <= 1'b0;
		end else begin
			valid_d <= (state == RUN);
		end
	end

	always_ff @(posedge elem) begin
		amp_d <= amp_a; // travels with its sample.
	end

	assign prod_i = $signed(env_q.i) * amp_d;
	assign prod_q = $signed(env_q.q) * amp_d;

	// q1.15 scaling, shift then truncate.
	// iq stays zero while idle so the summer can add it unconditionally.
	always_ff @(posedge elem) begin
		if (rst) begin
			valid <= 1'b0;
			iq <= '0;
		end else begin
			valid <= valid_d;
			if (valid_d) begin
				iq.i <= samp_t'(prod_i >>> (`QCTL_SAMP_W - 1));
				iq.q <= samp_t'(prod_q >>> (`QCTL_SAMP_W - 1));
			end else begin
				iq <= '0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/elem_cmd_decode.sv ====
// command intake over req/ack, free-running time counter and trigger dispatch to the elements.
`timescale 1ns/1ps
`default_nettype none

`include "qctl_defines.svh"

module elem_cmd_decode
	import qctl_cmd_pkg::*;
(
	input  wire logic                 elem,
	input  wire logic                 rst,
	input  wire logic                 cmd_req,
	input  wire wave_cmd_t            cmd,
	output logic                      cmd_ack,
	output time_t                     tcnt,
	output logic [`QCTL_NELEM-1:0]    start,
	output elem_start_t               start_cfg
);

	typedef enum logic [1:0] {
		IDLE,
		ACKED,
		WAIT_DROP
	} intake_state_t;

	intake_state_t state;
	wave_cmd_t     cmd_r;
	logic          pending;
	logic          accept;
	logic          fire;

	// take a new command only with nothing queued.
	assign accept = (state == IDLE) && cmd_req && !pending;
	assign fire = pending && (cmd_r.trigt == tcnt);
	assign cmd_ack = (state == ACKED);

	always_ff @(posedge elem) begin
		if (rst) begin
			tcnt <= '0;
		end else begin
			tcnt <= tcnt + 1'b1; // wraps.
		end
	end

	// four-phase intake.
	always_ff @(posedge elem) begin
		if (rst) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: if (accept) state <= ACKED;
				ACKED: if (!cmd_req) state <= WAIT_DROP; // ack drops next cycle.
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge elem) begin
		if (rst) begin
			pending <= 1'b0;
		end else if (accept) begin
			pending <= 1'b1;
		end else if (fire) begin
			pending <= 1'b0;
		end
	end

	always_ff @(posedge elem) begin
		if (accept) begin
			cmd_r <= cmd;
		end
	end

	// one-cycle strobe to the element picked by chan.
	always_ff @(posedge elem) begin
		if (rst) begin
			start <= '0;
		end else begin
			start <= '0;
			if (fire) begin
				start[cmd_r.chan] <= 1'b1;
			end
		end
	end

	always_ff @(posedge elem) begin
		if (fire) begin
			start_cfg.envstart <= cmd_r.envstart;
			start_cfg.envlength <= cmd_r.envlength;
			start_cfg.amp <= cmd_r.amp;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/elem_sum.sv ====
// sums the element I/Q streams in a pipelined adder tree and stamps each output with its time.
`timescale 1ns/1ps
`default_nettype none

`include "qctl_defines.svh"

module elem_sum
	import qctl_cmd_pkg::*, qctl_wave_pkg::*;
(
	input  wire logic                  elem,
	input  wire logic                  rst,
	input  wire logic [`QCTL_NELEM-1:0] in_valid,
	input  wire iq_t                   in_iq [`QCTL_NELEM],
	input  wire time_t                 tcnt,
	output logic                       out_valid,
	output iq_t                        out_iq,
	output time_t                      out_tcnt
);

	localparam int unsigned SUM_LAT = 3;

	iq_t        in_r [`QCTL_NELEM];
	iq_t        pair0;
	iq_t        pair1;
	logic [2:0] valid_sr;
	time_t      ts1;
	time_t      ts2;

	// component-wise add, overflow wraps.
	function automatic iq_t iq_add(input iq_t a, input iq_t b);
		iq_t s;
		s.i = a.i + b.i;
		s.q = a.q + b.q;
		return s;
	endfunction

	always_ff @(posedge elem) begin
		for (int n = 0; n < `QCTL_NELEM; n++) begin
			in_r[n] <= in_iq[n];
		end
		pair0 <= iq_add(in_r[0], in_r[1]);
		pair1 <= iq_add(in_r[2], in_r[3]);
		out_iq <= iq_add(pair0, pair1);
	end

	// stamp is the counter value of the cycle the sum leaves.
	always_ff @(posedge elem) begin
		if (rst) begin
			valid_sr <= '0;
			ts1 <= '0;
			ts2 <= '0;
			out_tcnt <= '0;
		end else begin
			valid_sr <= {valid_sr[1:0], |in_valid};
			ts1 <= tcnt + time_t'(SUM_LAT);
			ts2 <= ts1;
			out_tcnt <= ts2;
		end
	end

	assign out_valid = valid_sr[2];

endmodule

`default_nettype wire

// ==== hdl/wave_ctl_top.sv ====
// top of the pulse generator: command decoder, four waveform elements and the output summer.
`timescale 1ns/1ps
`default_nettype none

`include "qctl_defines.svh"

module wave_ctl_top
	import qctl_cmd_pkg::*, qctl_wave_pkg::*;
(
	input  wire logic      elem,
	input  wire logic      rst,
	input  wire logic      cmd_req,
	input  wire wave_cmd_t cmd,
	output logic           cmd_ack,
	input  wire logic      env_wr_valid,
	input  wire env_wr_t   env_wr,
	output logic           out_valid,
	output iq_t            out_iq,
	output time_t          out_tcnt
);

	time_t                         tcnt;
	logic [`QCTL_NELEM-1:0]        start;
	elem_start_t                   start_cfg;
	wire logic [`QCTL_NELEM-1:0]   elem_valid;
	wire iq_t                      elem_iq [`QCTL_NELEM];

	elem_cmd_decode decode0 (
		.elem      (elem),
		.rst       (rst),
		.cmd_req   (cmd_req),
		.cmd       (cmd),
		.cmd_ack   (cmd_ack),
		.tcnt      (tcnt),
		.start     (start),
		.start_cfg (start_cfg)
	);

	for (genvar g = 0; g < `QCTL_NELEM; g++) begin : g_elem
		elem_seq seq0 (
			.elem      (elem),
			.rst       (rst),
			.start     (start[g]),
			.cfg       (start_cfg),
			.env_wr_en (env_wr_valid && (env_wr.chan == chan_t'(g))), // this element's ram only.
			.env_wr    (env_wr),
			.valid     (elem_valid[g]),
			.iq        (elem_iq[g])
		);
	end

	elem_sum sum0 (
		.elem      (elem),
		.rst       (rst),
		.in_valid  (elem_valid),
		.in_iq     (elem_iq),
		.tcnt      (tcnt),
		.out_valid (out_valid),
		.out_iq    (out_iq),
		.out_tcnt  (out_tcnt)
	);

endmodule

`default_nettype wire

// ==== dv/wave_ctl_assertions.sv ====
// concurrent checks on the decoder's req/ack handshake and start strobe that are bound into elem_cmd_decode.
`timescale 1ns/1ps
`default_nettype none

`include "qctl_defines.svh"

module wave_ctl_assertions (
	input wire logic                   elem,
	input wire logic                   rst,
	input wire logic                   cmd_req,
	input wire logic                   cmd_ack,
	input wire logic [`QCTL_NELEM-1:0] start
);

	int unsigned fail_count = 0; // watched by the testbench monitor.

	// ack is registered, so the request it answers was seen one edge earlier.
	ack_rise_with_req: assert property (@(posedge elem) disable iff (rst)
		$rose(cmd_ack) |-> $past(cmd_req))
		else begin
			$error("cmd_ack rose while cmd_req was low");
			fail_count++;
		end

	ack_fall_after_drop: assert property (@(posedge elem) disable iff (rst)
		$fell(cmd_ack) |-> $past(!cmd_req))
		else begin
			$error("cmd_ack fell before cmd_req dropped");
			fail_count++;
		end

	ack_held_with_req: assert property (@(posedge elem) disable iff (rst)
		(cmd_ack && cmd_req) |=> cmd_ack)
		else begin
			$error("cmd_ack dropped while cmd_req was still high");
			fail_count++;
		end

	start_onehot0: assert property (@(posedge elem) disable iff (rst)
		$onehot0(start))
		else begin
			$error("more than one start bit set");
			fail_count++;
		end

endmodule

bind elem_cmd_decode wave_ctl_assertions chk0 (
	.elem    (elem),
	.rst     (rst),
	.cmd_req (cmd_req),
	.cmd_ack (cmd_ack),
	.start   (start)
);

`default_nettype wire

// ==== dv/tb_wave_ctl.sv ====
// simulation top that drives random envelopes and timed commands into the pulse generator and checks its summed output.
`timescale 1ns/1ps
`default_nettype none

`include "qctl_defines.svh"

module tb_wave_ctl
	import qctl_cmd_pkg::*, qctl_wave_pkg::*;
();

	localparam int CLK_PERIOD = 8;
	localparam int SPAN = 8192;                  // model time slots beyond the run length.
	localparam int ENV_DEPTH = 1 << `QCTL_ENV_AW;
	localparam int OUT_LAT = 7;                  // trigger to first output sample.
	localparam int N_SINGLE = 12;
	localparam int N_RAND = 24;
	localparam int N_CMDS = N_SINGLE + 4 + N_RAND;
	localparam int MAX_GAP = 96;                 // worst cycles per command incl. drain.
	localparam int LOAD_CYCLES = `QCTL_NELEM * ENV_DEPTH + 50;

	logic      elem;
	logic      rst;
	logic      cmd_req;
	wave_cmd_t cmd;
	logic      cmd_ack;
	logic      env_wr_valid;
	env_wr_t   env_wr;
	logic      out_valid;
	iq_t       out_iq;
	time_t     out_tcnt;

	// reference model state.
	iq_t    env_mem [`QCTL_NELEM][ENV_DEPTH];
	samp_t  contrib_i [`QCTL_NELEM][SPAN];
	samp_t  contrib_q [`QCTL_NELEM][SPAN];
	bit     contrib_v [`QCTL_NELEM][SPAN];
	integer seed;
	int     tnow;       // mirrors the decoder's time counter.
	int     last_trigt;
	int     n_sent;
	int     ack_rises;
	int     ack_falls;
	logic   ack_prev;

	wave_ctl_top dut0 (
		.elem         (elem),
		.rst          (rst),
		.cmd_req      (cmd_req),
		.cmd          (cmd),
		.cmd_ack      (cmd_ack),
		.env_wr_valid (env_wr_valid),
		.env_wr       (env_wr),
		.out_valid    (out_valid),
		.out_iq       (out_iq),
		.out_tcnt     (out_tcnt)
	);

	initial begin
		elem = 1'b0;
		forever #(CLK_PERIOD / 2) elem = ~elem;
	end

	always @(posedge elem) begin
		if (rst) begin
			tnow <= 0;
		end else begin
			tnow <= tnow + 1;
		end
	end

	task automatic report_fail(input string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1, "stopping at first error");
	endtask

	function automatic int rand_below(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	// q1.15 product shifted right by 15 and cut to its low 16 bits.
	function automatic samp_t scale(input samp_t s, input amp_t a);
		logic signed [31:0] p;
		p = s * a;
		p = p >>> 15;
		return p[15:0];
	endfunction

	function automatic amp_t pick_amp(input int j);
		case (j % 5)
			0: return amp_t'(16'h8000); // -1.0 at full scale.
			1: return amp_t'(16'h7fff);
			2: return amp_t'(16'hffff);
			default: return amp_t'($random(seed));
		endcase
	endfunction

	// a later start on the same element replaces the rest of its pulse.
	function automatic void add_pulse(input int e, input int trigt, input int envstart,
			input int envlength, input amp_t amp);
		int t0;
		int a;
		t0 = trigt + OUT_LAT;
		for (int t = t0; t < t0 + ENV_DEPTH; t++) begin
			contrib_v[e][t % SPAN] = 1'b0;
		end
		for (int k = 0; k <= envlength; k++) begin
			a = (envstart + k) % ENV_DEPTH;
			contrib_v[e][(t0 + k) % SPAN] = 1'b1;
			contrib_i[e][(t0 + k) % SPAN] = scale(env_mem[e][a].i, amp);
			contrib_q[e][(t0 + k) % SPAN] = scale(env_mem[e][a].q, amp);
		end
	endfunction

	task automatic wait_until(input int t);
		while (tnow < t) begin
			@(posedge elem);
			#1;
		end
	endtask

	task automatic load_env(input int e, input int addr, input iq_t data);
		env_wr_valid = 1'b1;
		env_wr.chan = chan_t'(e);
		env_wr.addr = env_addr_t'(addr);
		env_wr.data = data;
		env_mem[e][addr] = data;
		@(posedge elem);
		#1;
		env_wr_valid = 1'b0;
	endtask

	task automatic send_cmd(input int e, input int trigt, input int envstart,
			input int envlength, input amp_t amp);
		wave_cmd_t c;
		int ack_cycle;
		int hold;
		c.chan = chan_t'(e);
		c.trigt = time_t'(trigt);
		c.envstart = env_addr_t'(envstart);
		c.envlength = env_addr_t'(envlength);
		c.amp = amp;
		c.rsvd = '0;
		add_pulse(e, trigt, envstart, envlength, amp);
		cmd = c;
		cmd_req = 1'b1;
		n_sent++;
		do begin
			@(posedge elem);
			#1;
		end while (!cmd_ack);
		ack_cycle = tnow;
		assert (ack_cycle > last_trigt) else
			report_fail($sformatf("command %0d was acked at tcnt %0d while the one for %0d pended",
				n_sent, ack_cycle, last_trigt));
		last_trigt = trigt;
		hold = rand_below(4); // host keeps req up a few cycles after the ack.
		repeat (hold) begin
			@(posedge elem);
			#1;
			assert (cmd_ack === 1'b1) else
				report_fail($sformatf("FAILED at %0t: cmd_ack expected 1 got %0b",
					$time, cmd_ack));
		end
		cmd_req = 1'b0;
		@(posedge elem);
		#1;
		assert (cmd_ack === 1'b0) else
			report_fail($sformatf("FAILED at %0t: cmd_ack expected 0 got %0b", $time, cmd_ack));
	endtask

	// outputs are sampled mid-cycle.
	always @(negedge elem) begin : check_outputs
		logic  exp_v;
		samp_t exp_i;
		samp_t exp_q;
		int    idx;
		if (!rst) begin
			idx = tnow % SPAN;
			exp_v = 1'b0;
			exp_i = '0;
			exp_q = '0;
			for (int e = 0; e < `QCTL_NELEM; e++) begin
				if (contrib_v[e][idx]) begin
					exp_v = 1'b1;
					exp_i = exp_i + contrib_i[e][idx]; // wraps at 16 bits.
					exp_q = exp_q + contrib_q[e][idx];
				end
			end
			assert (out_valid === exp_v) else
				report_fail($sformatf("FAILED at %0t: out_valid expected %0b got %0b",
					$time, exp_v, out_valid));
			if (exp_v) begin
				assert (out_tcnt === time_t'(tnow)) else
					report_fail($sformatf("FAILED at %0t: out_tcnt expected %0d got %0d",
						$time, tnow, out_tcnt));
				assert (out_iq.i === exp_i) else
					report_fail($sformatf("FAILED at %0t: out_iq.i expected %0d got %0d",
						$time, exp_i, out_iq.i));
				assert (out_iq.q === exp_q) else
					report_fail($sformatf("FAILED at %0t: out_iq.q expected %0d got %0d",
						$time, exp_q, out_iq.q));
			end
			if (n_sent == 0) begin
				assert (cmd_ack === 1'b0) else
					report_fail($sformatf("FAILED at %0t: cmd_ack expected 0 got %0b",
						$time, cmd_ack));
			end
			if (cmd_ack && !ack_prev) ack_rises++;
			if (!cmd_ack && ack_prev) ack_falls++;
			ack_prev = cmd_ack;
			assert (dut0.decode0.chk0.fail_count == 0) else
				report_fail("a bound assertion on the command decoder failed");
		end
	end

	initial begin
		#((LOAD_CYCLES + N_CMDS * MAX_GAP + 300) * CLK_PERIOD);
		report_fail("watchdog expired before the test sequence finished");
	end

	initial begin
		iq_t data;
		int  e;
		int  len;
		int  trig;
		seed = 32'h6d431bb5;
		rst = 1'b1;
		cmd_req = 1'b0;
		cmd = '0;
		env_wr_valid = 1'b0;
		env_wr = '0;
		last_trigt = -1;
		n_sent = 0;
		ack_rises = 0;
		ack_falls = 0;
		ack_prev = 1'b0;
		repeat (3) @(posedge elem);
		#1;
		rst = 1'b0;
		repeat (20) @(posedge elem); // quiet after reset.
		#1;

		for (int ch = 0; ch < `QCTL_NELEM; ch++) begin
			for (int a = 0; a < ENV_DEPTH; a++) begin
				data = iq_t'($random(seed));
				if (a == 0) begin
					data.i = samp_t'(16'h8000); // extremes for the scaling corners.
					data.q = samp_t'(16'h7fff);
				end
				load_env(ch, a, data);
			end
		end

		// one pulse at a time.
		for (int j = 0; j < N_SINGLE; j++) begin
			e = rand_below(`QCTL_NELEM);
			len = rand_below(32);
			trig = tnow + 6 + rand_below(16);
			send_cmd(e, trig, (j == 0) ? 0 : rand_below(ENV_DEPTH), len, pick_amp(j));
			wait_until(trig + OUT_LAT + len + 3);
		end

		// second command waits behind a pending one.
		trig = tnow + 40;
		send_cmd(0, trig, rand_below(ENV_DEPTH), 29, pick_amp(3));
		send_cmd(1, trig + 20, rand_below(ENV_DEPTH), 15, pick_amp(4));
		wait_until(trig + 20 + OUT_LAT + 16 + 3);

		// restart of a busy element.
		trig = tnow + 10;
		send_cmd(2, trig, rand_below(ENV_DEPTH), 40, pick_amp(1));
		send_cmd(2, trig + 15, rand_below(ENV_DEPTH), 10, pick_amp(0));
		wait_until(trig + 15 + OUT_LAT + 11 + 3);

		// dense random traffic with overlapping and restarting pulses.
		for (int j = 0; j < N_RAND; j++) begin
			trig = last_trigt + 3 + rand_below(12);
			if (trig < tnow + 6) trig = tnow + 6;
			send_cmd(rand_below(`QCTL_NELEM), trig, rand_below(ENV_DEPTH), rand_below(48),
				pick_amp(j));
		end
		wait_until(last_trigt + OUT_LAT + 48 + 4);

		if ((ack_rises == n_sent) && (ack_falls == n_sent)) begin
			$display("Test completed successfully");
			$finish;
		end else begin
			report_fail($sformatf("handshake count wrong: %0d commands, %0d ack rises, %0d falls",
				n_sent, ack_rises, ack_falls));
		end
	end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+common
common/qctl_cmd_pkg.sv
common/qctl_wave_pkg.sv
element/env_ram.sv
element/elem_seq.sv
hdl/elem_cmd_decode.sv
hdl/elem_sum.sv
hdl/wave_ctl_top.sv
dv/wave_ctl_assertions.sv
dv/tb_wave_ctl.sv

// ==== Bender.yml ====
package:
  name: qctl_wave_ctl

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/qctl_cmd_pkg.sv
      - common/qctl_wave_pkg.sv
      - element/env_ram.sv
      - element/elem_seq.sv
      - hdl/elem_cmd_decode.sv
      - hdl/elem_sum.sv
      - hdl/wave_ctl_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - dv/wave_ctl_assertions.sv
      - dv/tb_wave_ctl.sv
